// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_idma_transport_layer \
    && ./obj_dir/Vtb_idma_transport_layer > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

// File: tb.f
+incdir+verilog
verilog/idma_stream_pkg.sv
verilog/idma_xfer_pkg.sv
verilog/idma_stream_read.sv
verilog/idma_lane_buffer.sv
verilog/idma_stream_write.sv
verilog/idma_transport_layer.sv
tb/tb_idma_transport_layer.sv

// File: tb/tb_idma_transport_layer.sv
// Transport layer testbench with reference model, random stimulus, monitors and watchdog
`timescale 1ns/1ns
`include "idma_config.svh"

module tb_idma_transport_layer
    import idma_stream_pkg::*;
    import idma_xfer_pkg::*;
();

    localparam int lanes          = `IDMA_STRB_WIDTH;
    localparam int n_aligned      = 4;
    localparam int n_random       = 40;
    localparam int n_xfers        = n_aligned + n_random;
    localparam int timeout_cycles = 200 * n_xfers + 100;

    logic         clk;
    logic         rst_n;
    r_dp_req_t    r_req;
    logic         r_req_valid;
    logic         r_req_ready;
    dp_rsp_t      r_rsp;
    logic         r_rsp_valid;
    logic         r_rsp_ready;
    w_dp_req_t    w_req;
    logic         w_req_valid;
    logic         w_req_ready;
    dp_rsp_t      w_rsp;
    logic         w_rsp_valid;
    logic         w_rsp_ready;
    stream_beat_t src;
    logic         src_valid;
    logic         src_ready;
    stream_beat_t dst;
    logic         dst_valid;
    logic         dst_ready;
    logic         r_busy;
    logic         w_busy;
    logic         buffer_busy;

    logic [31:0]  rng_state = 32'hdfb3b43b;
    logic         stress;
    byte_t        xfer_bytes [64];
    stream_beat_t exp_q [$];
    int           r_rsp_count;
    int           w_rsp_count;
    int           dst_beats;

    idma_transport_layer UUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .r_req_i(r_req), .r_req_valid_i(r_req_valid), .r_req_ready_o(r_req_ready),
        .r_rsp_o(r_rsp), .r_rsp_valid_o(r_rsp_valid), .r_rsp_ready_i(r_rsp_ready),
        .w_req_i(w_req), .w_req_valid_i(w_req_valid), .w_req_ready_o(w_req_ready),
        .w_rsp_o(w_rsp), .w_rsp_valid_o(w_rsp_valid), .w_rsp_ready_i(w_rsp_ready),
        .src_i(src), .src_valid_i(src_valid), .src_ready_o(src_ready),
        .dst_o(dst), .dst_valid_o(dst_valid), .dst_ready_i(dst_ready),
        .r_busy_o(r_busy), .w_busy_o(w_busy), .buffer_busy_o(buffer_busy)
    );

    // ------------------------------------------------------------------------
    // Helpers and reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s: got 'h%0h, expected 'h%0h",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Beats spanned by n bytes starting in lane off
    function automatic int beat_count(input int off, input int n);
        return (off + n + lanes - 1) / lanes;
    endfunction

    // Expected destination beat k with byte i in lane (d+i) mod lanes
    function automatic stream_beat_t ref_beat(input int d, input int n, input int k);
        stream_beat_t beat;
        int           pos;
        beat = '0;
        for (int l = 0; l < lanes; l++) begin
            pos = k * lanes + l - d;
            if (pos >= 0 && pos < n) begin
                beat.strb[l] = 1'b1;
                beat.data[l] = xfer_bytes[pos];
            end
        end
        beat.last = (k == beat_count(d, n) - 1);
        return beat;
    endfunction

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------

    task automatic send_requests(input int s, input int d, input int n);
        logic r_done;
        logic w_done;
        r_req.offset = lane_idx_t'(s);
        r_req.shift  = lane_idx_t'((d - s + lanes) % lanes);
        r_req.length = xfer_len_t'(n);
        w_req.offset = lane_idx_t'(d);
        w_req.length = xfer_len_t'(n);
        r_req_valid  = 1'b1;
        w_req_valid  = 1'b1;
        r_done = 1'b0;
        w_done = 1'b0;
        while (!(r_done && w_done)) begin
            @(posedge clk);
            if (r_req_valid && r_req_ready) r_done = 1'b1;
            if (w_req_valid && w_req_ready) w_done = 1'b1;
            #1;
            if (r_done) r_req_valid = 1'b0;
            if (w_done) w_req_valid = 1'b0;
        end
    endtask

    task automatic send_source(input int s, input int n);
        logic [31:0] r;
        int          pos;
        logic        taken;
        for (int k = 0; k < beat_count(s, n); k++) begin
            // Idle cycles between beats under stress
            next_rand(r);
            while (stress && r[1:0] == 2'd0) begin
                src_valid = 1'b0;
                @(posedge clk);
                #1;
                next_rand(r);
            end
            for (int l = 0; l < lanes; l++) begin
                pos = k * lanes + l - s;
                next_rand(r);
                src.strb[l] = (pos >= 0 && pos < n);
                src.data[l] = src.strb[l] ? xfer_bytes[pos] : r[7:0];
            end
            src.last  = (k == beat_count(s, n) - 1);
            src_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = src_ready;
            end
            #1;
        end
        src_valid = 1'b0;
    endtask

    task automatic run_transfer(input int s, input int d, input int n, input int idx);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            next_rand(r);
            xfer_bytes[i] = r[7:0];
        end
        for (int k = 0; k < beat_count(d, n); k++) begin
            exp_q.push_back(ref_beat(d, n, k));
        end
        send_requests(s, d, n);
        send_source(s, n);
        while (r_rsp_count <= idx || w_rsp_count <= idx) begin
            @(posedge clk);
            #1;
        end
        check_eq(64'(exp_q.size()), 64'd0, $sformatf("transfer %0d beats missing", idx));
        check_eq(64'(r_rsp_count), 64'(idx + 1), "read response count");
        check_eq(64'(w_rsp_count), 64'(idx + 1), "write response count");
    endtask

    // ------------------------------------------------------------------------
    // Processes
    // ------------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Destination back-pressure
    initial begin : sink
        logic [31:0] r;
        dst_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (stress) begin
                next_rand(r);
                dst_ready = (r[1:0] != 2'd0);
            end else begin
                dst_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        stream_beat_t exp_beat;
        if (rst_n && dst_valid && dst_ready) begin
            check_eq(64'(exp_q.size() != 0), 64'd1, "destination beat with none expected");
            exp_beat = exp_q.pop_front();
            check_eq(64'(dst.strb), 64'(exp_beat.strb), $sformatf("beat %0d strobe", dst_beats));
            check_eq(64'(dst.last), 64'(exp_beat.last), $sformatf("beat %0d last", dst_beats));
            for (int l = 0; l < lanes; l++) begin
                if (exp_beat.strb[l]) begin
                    check_eq(64'(dst.data[l]), 64'(exp_beat.data[l]),
                             $sformatf("beat %0d lane %0d byte", dst_beats, l));
                end
            end
            dst_beats++;
        end
        if (rst_n && r_rsp_valid && r_rsp_ready) begin
            check_eq(64'(r_rsp.error), 64'd0, "read response error");
            check_eq(64'(r_rsp.last), 64'd1, "read response last");
            r_rsp_count++;
        end
        if (rst_n && w_rsp_valid && w_rsp_ready) begin
            check_eq(64'(w_rsp.error), 64'd0, "write response error");
            check_eq(64'(w_rsp.last), 64'd1, "write response last");
            w_rsp_count++;
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("ERROR: simulation timed out after %0d cycles", timeout_cycles);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [31:0] r;
        int          s;
        int          d;
        int          n;
        rst_n       = 1'b0;
        r_req       = '0;
        r_req_valid = 1'b0;
        r_rsp_ready = 1'b1;
        w_req       = '0;
        w_req_valid = 1'b0;
        w_rsp_ready = 1'b1;
        src         = '0;
        src_valid   = 1'b0;
        stress      = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        // Idle outputs after reset
        check_eq(64'(r_rsp_valid), 64'd0, "r_rsp_valid after reset");
        check_eq(64'(w_rsp_valid), 64'd0, "w_rsp_valid after reset");
        check_eq(64'(dst_valid), 64'd0, "dst_valid after reset");
        check_eq(64'(src_ready), 64'd0, "src_ready after reset");
        check_eq(64'({r_busy, w_busy, buffer_busy}), 64'd0, "busy flags after reset");
        check_eq(64'({r_req_ready, w_req_ready}), 64'd3, "request readies after reset");
        for (int x = 0; x < n_xfers; x++) begin
            next_rand(r);
            if (x < n_aligned) begin
                s = 0;
                d = 0;
                n = lanes * (1 + int'(r[2:0]));
            end else begin
                stress = 1'b1;
                s = int'(r[1:0]);
                d = int'(r[3:2]);
                n = 1 + int'(r[15:8]) % 40;
            end
            run_transfer(s, d, n, x);
        end
        repeat (4) @(posedge clk);
        #1;
        check_eq(64'({r_busy, w_busy, buffer_busy}), 64'd0, "busy flags at end");
        check_eq(64'(r_rsp_count), 64'(n_xfers), "final read response count");
        check_eq(64'(w_rsp_count), 64'(n_xfers), "final write response count");
        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/idma_config.svh
// Transport layer sizes: stream width, byte lanes, length width and lane FIFO depth
`ifndef IDMA_CONFIG_SVH
`define IDMA_CONFIG_SVH

// Stream data width in bits
`define IDMA_DATA_WIDTH 32

// Number of byte lanes per beat
`define IDMA_STRB_WIDTH (`IDMA_DATA_WIDTH / 8)

// Bits needed to name one lane
`define IDMA_LANE_W 2

// Transfer length in bytes
`define IDMA_LEN_W 16

// Entries per lane FIFO
`define IDMA_BUFFER_DEPTH 3

`endif

// File: verilog/idma_lane_buffer.sv
// Lane buffer: one small byte FIFO per lane with lane-wise valid and ready
`timescale 1ns/1ns
`include "idma_config.svh"

module idma_lane_buffer
    import idma_stream_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  lane_data_t data_i,
    input  lane_mask_t valid_i,
    output lane_mask_t ready_o,
    output lane_data_t data_o,
    output lane_mask_t valid_o,
    input  lane_mask_t ready_i,
    output logic       busy_o
);

    localparam int unsigned ptr_w = $clog2(`IDMA_BUFFER_DEPTH);
    localparam int unsigned cnt_w = $clog2(`IDMA_BUFFER_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`IDMA_BUFFER_DEPTH - 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`IDMA_BUFFER_DEPTH);

    for (genvar l = 0; l < `IDMA_STRB_WIDTH; l++) begin : gen_lane
        byte_t            mem_q [`IDMA_BUFFER_DEPTH];
        logic [ptr_w-1:0] rd_ptr_q;
        logic [ptr_w-1:0] wr_ptr_q;
        logic [cnt_w-1:0] count_q;
        logic             push;
        logic             pop;

        // Full lane stops accepting, independent of the pop side
        assign ready_o[l] = count_q != full_cnt;
        assign valid_o[l] = count_q != '0;
        assign data_o[l]  = mem_q[rd_ptr_q];

        assign push = valid_i[l] && ready_o[l];
        assign pop  = valid_o[l] && ready_i[l];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
                end
                if (push && !pop) begin
                    count_q <= count_q + 1'b1;
                end else if (pop && !push) begin
                    count_q <= count_q - 1'b1;
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wr_ptr_q] <= data_i[l];
            end
        end
    end

    // Any lane still holding bytes
    assign busy_o = |valid_o;

endmodule

// File: verilog/idma_stream_pkg.sv
// Stream beat and byte-lane types, with the lane window helper
`include "idma_config.svh"

package idma_stream_pkg;

    typedef logic [7:0]                  byte_t;
    typedef logic [`IDMA_STRB_WIDTH-1:0] lane_mask_t;
    typedef byte_t [`IDMA_STRB_WIDTH-1:0] lane_data_t;

    typedef struct packed {
        lane_data_t data;
        lane_mask_t strb;
        logic       last;
    } stream_beat_t;

    // Lanes holding transfer bytes, from lane start up to the bytes still left
    function automatic lane_mask_t beat_mask(
        input logic [`IDMA_LANE_W-1:0] start,
        input logic [`IDMA_LEN_W-1:0]  bytes_left
    );
        lane_mask_t mask;
        for (int l = 0; l < `IDMA_STRB_WIDTH; l++) begin
            mask[l] = (l >= int'(start)) && ((l - int'(start)) < int'(bytes_left));
        end
        return mask;
    endfunction

endpackage

// File: verilog/idma_stream_read.sv
// Read port: source beat masking, lane rotation and push into the lane buffer
`timescale 1ns/1ns
`include "idma_config.svh"

module idma_stream_read
    import idma_stream_pkg::*;
    import idma_xfer_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  r_dp_req_t    r_req_i,
    input  logic         r_req_valid_i,
    output logic         r_req_ready_o,
    output dp_rsp_t      r_rsp_o,
    output logic         r_rsp_valid_o,
    input  logic         r_rsp_ready_i,
    input  stream_beat_t src_i,
    input  logic         src_valid_i,
    output logic         src_ready_o,
    output lane_data_t   buf_in_data_o,
    output lane_mask_t   buf_in_valid_o,
    input  lane_mask_t   buf_in_ready_i,
    output logic         busy_o
);

    r_dp_req_t  req_q;
    logic       active_q;
    logic       first_q;
    logic       err_q;
    logic       rsp_valid_q;
    xfer_len_t  bytes_left_q;

    lane_idx_t  start_lane;
    xfer_len_t  beat_room;
    logic       last_beat;
    lane_mask_t src_mask;
    lane_mask_t rot_mask;
    lane_data_t rot_data;
    logic       req_take;
    logic       beat_take;

    // Lane window of the current source beat
    assign start_lane = first_q ? req_q.offset : '0;
    assign beat_room  = xfer_len_t'(`IDMA_STRB_WIDTH) - xfer_len_t'(start_lane);
    assign last_beat  = bytes_left_q <= beat_room;
    assign src_mask   = beat_mask(start_lane, bytes_left_q);

    // Rotate left so each byte lands in its destination lane
    always_comb begin
        rot_data = '0;
        rot_mask = '0;
        for (int l = 0; l < `IDMA_STRB_WIDTH; l++) begin
            rot_data[lane_idx_t'(l) + req_q.shift] = src_i.data[l];
            rot_mask[lane_idx_t'(l) + req_q.shift] = src_mask[l];
        end
    end

    // --------------------------------------------------------------------------
    // Handshakes
    // --------------------------------------------------------------------------

    assign r_req_ready_o = !active_q && !rsp_valid_q;
    assign req_take      = r_req_valid_i && r_req_ready_o;

    // Whole beat or nothing
    assign src_ready_o    = active_q && ((buf_in_ready_i & rot_mask) == rot_mask);
    assign beat_take      = src_valid_i && src_ready_o;
    assign buf_in_data_o  = rot_data;
    assign buf_in_valid_o = beat_take ? rot_mask : '0;

    assign r_rsp_o       = '{error: err_q, last: 1'b1};
    assign r_rsp_valid_o = rsp_valid_q;
    assign busy_o        = active_q || rsp_valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q     <= 1'b0;
            first_q      <= 1'b0;
            err_q        <= 1'b0;
            rsp_valid_q  <= 1'b0;
            bytes_left_q <= '0;
        end else begin
            if (req_take) begin
                active_q     <= 1'b1;
                first_q      <= 1'b1;
                err_q        <= 1'b0;
                bytes_left_q <= r_req_i.length;
            end else if (beat_take) begin
                first_q      <= 1'b0;
                bytes_left_q <= last_beat ? '0 : bytes_left_q - beat_room;
                // Source last flag must agree with the computed final beat
                err_q        <= err_q | (src_i.last != last_beat);
                if (last_beat) begin
                    active_q <= 1'b0;
                end
            end
            if (beat_take && last_beat) begin
                rsp_valid_q <= 1'b1;
            end else if (r_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_take) begin
            req_q <= r_req_i;
        end
    end

endmodule

// File: verilog/idma_stream_write.sv
// Write port: drains lane buffer into strobed destination beats with last flag
`timescale 1ns/1ns
`include "idma_config.svh"

module idma_stream_write
    import idma_stream_pkg::*;
    import idma_xfer_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  w_dp_req_t    w_req_i,
    input  logic         w_req_valid_i,
    output logic         w_req_ready_o,
    output dp_rsp_t      w_rsp_o,
    output logic         w_rsp_valid_o,
    input  logic         w_rsp_ready_i,
    input  lane_data_t   buf_out_data_i,
    input  lane_mask_t   buf_out_valid_i,
    output lane_mask_t   buf_out_ready_o,
    output stream_beat_t dst_o,
    output logic         dst_valid_o,
    input  logic         dst_ready_i,
    output logic         busy_o
);

    w_dp_req_t  req_q;
    logic       active_q;
    logic       first_q;
    logic       rsp_valid_q;
    xfer_len_t  bytes_left_q;

    lane_idx_t  start_lane;
    xfer_len_t  beat_room;
    logic       last_beat;
    lane_mask_t dst_mask;
    logic       req_take;
    logic       beat_take;

    // --------------------------------------------------------------------------
    // Beat shape
    // --------------------------------------------------------------------------

    // First beat starts at the destination offset, later ones at lane 0
    assign start_lane = first_q ? req_q.offset : '0;
    assign beat_room  = xfer_len_t'(`IDMA_STRB_WIDTH) - xfer_len_t'(start_lane);
    assign last_beat  = bytes_left_q <= beat_room;
    assign dst_mask   = beat_mask(start_lane, bytes_left_q);

    assign dst_o = '{data: buf_out_data_i, strb: dst_mask, last: last_beat};

    // Beat is complete once every strobed lane has a byte waiting
    assign dst_valid_o = active_q && ((buf_out_valid_i & dst_mask) == dst_mask);
    assign beat_take   = dst_valid_o && dst_ready_i;

    // Pop exactly the strobed lanes, and only on acceptance
    assign buf_out_ready_o = beat_take ? dst_mask : '0;

    // --------------------------------------------------------------------------
    // Request and response
    // --------------------------------------------------------------------------

    assign w_req_ready_o = !active_q && !rsp_valid_q;
    assign req_take      = w_req_valid_i && w_req_ready_o;

    assign w_rsp_o       = '{error: 1'b0, last: 1'b1};
    assign w_rsp_valid_o = rsp_valid_q;
    assign busy_o        = active_q || rsp_valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q     <= 1'b0;
            first_q      <= 1'b0;
            rsp_valid_q  <= 1'b0;
            bytes_left_q <= '0;
        end else begin
            if (req_take) begin
                active_q     <= 1'b1;
                first_q      <= 1'b1;
                bytes_left_q <= w_req_i.length;
            end else if (beat_take) begin
                first_q      <= 1'b0;
                bytes_left_q <= last_beat ? '0 : bytes_left_q - beat_room;
                if (last_beat) begin
                    active_q <= 1'b0;
                end
            end
            if (beat_take && last_beat) begin
                rsp_valid_q <= 1'b1;
            end else if (w_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_take) begin
            req_q <= w_req_i;
        end
    end

endmodule

// File: verilog/idma_transport_layer.sv
// Transport layer top: read port, per-lane buffer and write port
`timescale 1ns/1ns

module idma_transport_layer
    import idma_stream_pkg::*;
    import idma_xfer_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    // Read datapath
    input  r_dp_req_t    r_req_i,
    input  logic         r_req_valid_i,
    output logic         r_req_ready_o,
    output dp_rsp_t      r_rsp_o,
    output logic         r_rsp_valid_o,
    input  logic         r_rsp_ready_i,
    // Write datapath
    input  w_dp_req_t    w_req_i,
    input  logic         w_req_valid_i,
    output logic         w_req_ready_o,
    output dp_rsp_t      w_rsp_o,
    output logic         w_rsp_valid_o,
    input  logic         w_rsp_ready_i,
    // Streams
    input  stream_beat_t src_i,
    input  logic         src_valid_i,
    output logic         src_ready_o,
    output stream_beat_t dst_o,
    output logic         dst_valid_o,
    input  logic         dst_ready_i,
    // Status
    output logic         r_busy_o,
    output logic         w_busy_o,
    output logic         buffer_busy_o
);

    // Bytes already sitting in their destination lanes
    lane_data_t buf_in_data;
    lane_mask_t buf_in_valid;
    lane_mask_t buf_in_ready;
    lane_data_t buf_out_data;
    lane_mask_t buf_out_valid;
    lane_mask_t buf_out_ready;

    idma_stream_read u_read (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .r_req_i        (r_req_i),
        .r_req_valid_i  (r_req_valid_i),
        .r_req_ready_o  (r_req_ready_o),
        .r_rsp_o        (r_rsp_o),
        .r_rsp_valid_o  (r_rsp_valid_o),
        .r_rsp_ready_i  (r_rsp_ready_i),
        .src_i          (src_i),
        .src_valid_i    (src_valid_i),
        .src_ready_o    (src_ready_o),
        .buf_in_data_o  (buf_in_data),
        .buf_in_valid_o (buf_in_valid),
        .buf_in_ready_i (buf_in_ready),
        .busy_o         (r_busy_o)
    );

    idma_lane_buffer u_buffer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (buf_in_data),
        .valid_i (buf_in_valid),
        .ready_o (buf_in_ready),
        .data_o  (buf_out_data),
        .valid_o (buf_out_valid),
        .ready_i (buf_out_ready),
        .busy_o  (buffer_busy_o)
    );

    idma_stream_write u_write (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .w_req_i         (w_req_i),
        .w_req_valid_i   (w_req_valid_i),
        .w_req_ready_o   (w_req_ready_o),
        .w_rsp_o         (w_rsp_o),
        .w_rsp_valid_o   (w_rsp_valid_o),
        .w_rsp_ready_i   (w_rsp_ready_i),
        .buf_out_data_i  (buf_out_data),
        .buf_out_valid_i (buf_out_valid),
        .buf_out_ready_o (buf_out_ready),
        .dst_o           (dst_o),
        .dst_valid_o     (dst_valid_o),
        .dst_ready_i     (dst_ready_i),
        .busy_o          (w_busy_o)
    );

endmodule

// File: verilog/idma_xfer_pkg.sv
// Read and write datapath request and response types
`include "idma_config.svh"

package idma_xfer_pkg;

    typedef logic [`IDMA_LANE_W-1:0] lane_idx_t;
    typedef logic [`IDMA_LEN_W-1:0]  xfer_len_t;

    // --------------------------------------------------------------------------
    // Requests
    // --------------------------------------------------------------------------

    // Read side
    // Shift is the destination offset minus the source offset, modulo lanes
    typedef struct packed {
        lane_idx_t offset;
        lane_idx_t shift;
        xfer_len_t length;
    } r_dp_req_t;

    // Write side
    typedef struct packed {
        lane_idx_t offset;
        xfer_len_t length;
    } w_dp_req_t;

    // --------------------------------------------------------------------------
    // Responses
    // --------------------------------------------------------------------------

    typedef struct packed {
        logic error;
        logic last;
    } dp_rsp_t;

endpackage
